// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --assert -j 0
TOP   = tb_controlTop
FLIST = verilog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

# the ROM loads program.hex from the run directory
sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)
	cd sim && ../$(OBJ)/V$(TOP) 2>&1 | tee ../$(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== common/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    localparam int XLEN       = 32;
    localparam int IMEM_DEPTH = 16;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7; // imm[11:5] for I-type
            logic [4:0] rs2;    // imm[4:0] for I-type
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } ri;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sb;
    } instrWord_u;

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_OPIMM  = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_SUB = 3'b001;
    localparam logic [2:0] ALU_AND = 3'b010;
    localparam logic [2:0] ALU_OR  = 3'b011;
    localparam logic [2:0] ALU_XOR = 3'b100;
    localparam logic [2:0] ALU_SLT = 3'b101;
    localparam logic [2:0] ALU_SLL = 3'b110;
    localparam logic [2:0] ALU_SRL = 3'b111;

    localparam logic [2:0] IMM_I = 3'b000;
    localparam logic [2:0] IMM_S = 3'b001;
    localparam logic [2:0] IMM_B = 3'b010;
    localparam logic [2:0] IMM_J = 3'b011;
    localparam logic [2:0] IMM_U = 3'b100;

    localparam logic [1:0] RES_ALU = 2'b00;
    localparam logic [1:0] RES_MEM = 2'b01;
    localparam logic [1:0] RES_PC4 = 2'b10;

    localparam logic [1:0] MW_NONE = 2'b00;
    localparam logic [1:0] MW_BYTE = 2'b01;
    localparam logic [1:0] MW_HALF = 2'b10;
    localparam logic [1:0] MW_WORD = 2'b11;

    // enable in bit 2, load size below
    localparam logic [2:0] RW_NONE = 3'b000;
    localparam logic [2:0] RW_BYTE = 3'b100;
    localparam logic [2:0] RW_HALF = 3'b101;
    localparam logic [2:0] RW_WORD = 3'b110;

    localparam logic [1:0] PC_SEQ    = 2'b00;
    localparam logic [1:0] PC_BRANCH = 2'b01;
    localparam logic [1:0] PC_JUMP   = 2'b10;

endpackage

`default_nettype wire

// ==== decode/ctrlDecoder.sv ====
`default_nettype none

module ctrlDecoder
    import ctrlPkg::*;
(
    input  instrWord_u  instr_i,
    output logic [2:0]  regWrite_o,
    output logic [1:0]  memWrite_o,
    output logic [1:0]  resultSrc_o,
    output logic [2:0]  aluControl_o,
    output logic        aluSrc_o,
    output logic [2:0]  immSrc_o,
    output logic        jump_o,
    output logic        branch_o
);

    logic [6:0] op;
    logic [2:0] f3;
    logic       f7b5;
    logic       legal;

    assign op   = instr_i.ri.opcode;
    assign f3   = instr_i.ri.funct3;
    assign f7b5 = instr_i.ri.funct7[5];

    always_comb begin
        regWrite_o   = RW_NONE;
        memWrite_o   = MW_NONE;
        resultSrc_o  = RES_ALU;
        aluControl_o = ALU_ADD;
        aluSrc_o     = 1'b0;
        immSrc_o     = IMM_I;
        jump_o       = 1'b0;
        branch_o     = 1'b0;
        legal        = 1'b1;
        case (op)
            OP_LOAD: begin
                aluSrc_o    = 1'b1;
                resultSrc_o = RES_MEM;
                case (f3)
                    3'b000:  regWrite_o = RW_BYTE;
                    3'b001:  regWrite_o = RW_HALF;
                    3'b010:  regWrite_o = RW_WORD;
                    default: legal = 1'b0; // lbu, lhu
                endcase
            end
            OP_STORE: begin
                aluSrc_o = 1'b1;
                immSrc_o = IMM_S;
                case (f3)
                    3'b000:  memWrite_o = MW_BYTE;
                    3'b001:  memWrite_o = MW_HALF;
                    3'b010:  memWrite_o = MW_WORD;
                    default: legal = 1'b0;
                endcase
            end
            OP_OPIMM, OP_OP: begin
                regWrite_o = RW_WORD;
                aluSrc_o   = (op == OP_OPIMM);
                case (f3)
                    3'b000:  aluControl_o = (op == OP_OP && f7b5) ? ALU_SUB : ALU_ADD;
                    3'b111:  aluControl_o = ALU_AND;
                    3'b110:  aluControl_o = ALU_OR;
                    3'b100:  aluControl_o = ALU_XOR;
                    3'b010:  aluControl_o = ALU_SLT;
                    3'b001:  aluControl_o = ALU_SLL;
                    3'b101:  aluControl_o = ALU_SRL;
                    default: legal = 1'b0; // sltu, sltiu
                endcase
                // bit 30 is immediate data on addi etc, so only shifts and OP care
                if (f7b5 && (op == OP_OP ? f3 != 3'b000 : f3[1:0] == 2'b01))
                    legal = 1'b0; // sra, srai
            end
            OP_BRANCH: begin
                aluControl_o = ALU_SUB;
                immSrc_o     = IMM_B;
                branch_o     = 1'b1;
                if (f3[2:1] != 2'b00) legal = 1'b0; // beq, bne only
            end
            OP_JAL: begin
                regWrite_o  = RW_WORD;
                resultSrc_o = RES_PC4;
                immSrc_o    = IMM_J;
                jump_o      = 1'b1;
            end
            OP_LUI: begin
                regWrite_o = RW_WORD;
                aluSrc_o   = 1'b1;
                immSrc_o   = IMM_U;
            end
            default: legal = 1'b0; // jalr, auipc, system
        endcase
        if (!legal) begin
            regWrite_o   = RW_NONE;
            memWrite_o   = MW_NONE;
            resultSrc_o  = RES_ALU;
            aluControl_o = ALU_ADD;
            aluSrc_o     = 1'b0;
            immSrc_o     = IMM_I;
            jump_o       = 1'b0;
            branch_o     = 1'b0;
        end
    end

    // any write must come from a supported opcode
    aWriteLegalOp: assert final (
        !(regWrite_o[2] || memWrite_o != MW_NONE) ||
        op inside {OP_LOAD, OP_STORE, OP_OPIMM, OP_OP, OP_JAL, OP_LUI}
    ) else $error("write enable from illegal opcode %b", op);

endmodule

`default_nettype wire

// ==== decode/immExtend.sv ====
`default_nettype none

module immExtend
    import ctrlPkg::*;
(
    input  instrWord_u       instr_i,
    input  logic [2:0]       immSrc_i,
    output logic [XLEN-1:0]  extImm_o
);

    logic signBit;

    assign signBit = instr_i.ri.funct7[6]; // instr[31] in every format

    always_comb begin
        case (immSrc_i)
            IMM_I: extImm_o = {{20{signBit}},
                               instr_i.ri.funct7,
                               instr_i.ri.rs2};
            IMM_S: extImm_o = {{20{signBit}},
                               instr_i.sb.immHi,
                               instr_i.sb.immLo};
            // imm[11] sits in instr[7]
            IMM_B: extImm_o = {{20{signBit}},
                               instr_i.sb.immLo[0],
                               instr_i.sb.immHi[5:0],
                               instr_i.sb.immLo[4:1],
                               1'b0};
            // rs1/funct3 hold imm[19:12], rs2[0] is imm[11]
            IMM_J: extImm_o = {{12{signBit}},
                               instr_i.ri.rs1,
                               instr_i.ri.funct3,
                               instr_i.ri.rs2[0],
                               instr_i.ri.funct7[5:0],
                               instr_i.ri.rs2[4:1],
                               1'b0};
            IMM_U: extImm_o = {instr_i.ri.funct7,
                               instr_i.ri.rs2,
                               instr_i.ri.rs1,
                               instr_i.ri.funct3,
                               12'b0};
            default: extImm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== sim/program.hex ====
// one RV32I instruction word per line, ROM word 0 first
// words line up with the rows of the table in tb_controlTop
00500093 // addi x1, x0, 5
0080A103 // lw   x2, 8(x1)
FE208E23 // sb   x2, -4(x1)
002081B3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
00208463 // beq  x1, x2, +8
FE0198E3 // bne  x3, x0, -16
001000EF // jal  x1, +2048
123452B7 // lui  x5, 0x12345
0000C303 // lbu  x6, 0(x1), unsupported
000100E7 // jalr x1, 0(x2), unsupported
00501323 // sh   x5, 6(x0)
00309393 // slli x7, x1, 3
FFF14413 // xori x8, x2, -1
FFE19483 // lh   x9, -2(x3)
0020A533 // slt  x10, x1, x2

// ==== sim/tb_controlTop.sv ====
`default_nettype none

module tb_controlTop
    import ctrlPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD   = 40;
    localparam int RST_CYC  = 8;
    localparam int NROWS    = 16;
    localparam int BUB      = NROWS;  // all-zero row stands for a bubble
    localparam int STALL_AT = 6;
    localparam int STALLS   = 2;
    localparam int FLUSH_AT = 15;     // drops the slli sitting in D
    localparam int DRAIN    = 5;
    localparam int NSTEPS   = NROWS + STALLS + DRAIN;
    localparam int LIMIT_NS = (RST_CYC + NSTEPS + 10) * PERIOD;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] imm;
        logic [2:0]  alu;
        logic        aluSrc;
        logic [2:0]  regWrite;
        logic [1:0]  memWrite;
        logic [1:0]  resultSrc;
        logic [2:0]  jbf;  // jump, branch, funct3 bit 0
    } tblRow_t;

    logic        clk;
    logic        arstN;
    logic [31:0] pcF;
    logic        fEn;
    logic        fClr;
    logic        dEn;
    logic        dClr;
    logic        zeroE;
    logic [31:0] instrD;
    logic [31:0] pcD;
    logic [31:0] pcPlus4D;
    logic [31:0] extImmD;
    logic [2:0]  aluControlE;
    logic        aluSrcE;
    logic [1:0]  pcSrcE;
    logic [2:0]  regWriteM;
    logic [1:0]  memWriteM;
    logic [2:0]  regWriteW;
    logic [1:0]  resultSrcW;

    tblRow_t     tbl [NROWS+1];
    int          flight[$];  // E row per cycle, newest first
    int          dRow;
    logic [31:0] dPc;
    logic [31:0] dPc4;
    logic [31:0] lfsr;
    int          nextRow;
    int          errors;
    int          checks;

    controlTop i_dut (
        .clk           (clk),
        .arstN_i       (arstN),
        .pcF_i         (pcF),
        .fEn_i         (fEn),
        .fClr_i        (fClr),
        .dEn_i         (dEn),
        .dClr_i        (dClr),
        .zeroE_i       (zeroE),
        .instrD_o      (instrD),
        .pcD_o         (pcD),
        .pcPlus4D_o    (pcPlus4D),
        .extImmD_o     (extImmD),
        .aluControlE_o (aluControlE),
        .aluSrcE_o     (aluSrcE),
        .pcSrcE_o      (pcSrcE),
        .regWriteM_o   (regWriteM),
        .memWriteM_o   (memWriteM),
        .regWriteW_o   (regWriteW),
        .resultSrcW_o  (resultSrcW)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [1:0] expPcSrc(input tblRow_t r, input logic zero);
        if (r.jbf[2])
            return PC_JUMP;
        if (r.jbf[1] && (zero ^ r.jbf[0]))
            return PC_BRANCH;
        return PC_SEQ;
    endfunction

    task automatic checkVal(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic loadTable();
        tbl[0]  = '{'h00500093, 'h00000005, ALU_ADD, 1'b1, RW_WORD, MW_NONE, RES_ALU, 3'b000};
        tbl[1]  = '{'h0080A103, 'h00000008, ALU_ADD, 1'b1, RW_WORD, MW_NONE, RES_MEM, 3'b000};
        tbl[2]  = '{'hFE208E23, 'hFFFFFFFC, ALU_ADD, 1'b1, RW_NONE, MW_BYTE, RES_ALU, 3'b000};
        tbl[3]  = '{'h002081B3, 'h00000002, ALU_ADD, 1'b0, RW_WORD, MW_NONE, RES_ALU, 3'b000};
        tbl[4]  = '{'h40118233, 'h00000401, ALU_SUB, 1'b0, RW_WORD, MW_NONE, RES_ALU, 3'b000};
        tbl[5]  = '{'h00208463, 'h00000008, ALU_SUB, 1'b0, RW_NONE, MW_NONE, RES_ALU, 3'b010};
        tbl[6]  = '{'hFE0198E3, 'hFFFFFFF0, ALU_SUB, 1'b0, RW_NONE, MW_NONE, RES_ALU, 3'b011};
        tbl[7]  = '{'h001000EF, 'h00000800, ALU_ADD, 1'b0, RW_WORD, MW_NONE, RES_PC4, 3'b100};
        tbl[8]  = '{'h123452B7, 'h12345000, ALU_ADD, 1'b1, RW_WORD, MW_NONE, RES_ALU, 3'b001};
        tbl[9]  = '{'h0000C303, 'h00000000, ALU_ADD, 1'b0, RW_NONE, MW_NONE, RES_ALU, 3'b000};
        tbl[10] = '{'h000100E7, 'h00000000, ALU_ADD, 1'b0, RW_NONE, MW_NONE, RES_ALU, 3'b000};
        tbl[11] = '{'h00501323, 'h00000006, ALU_ADD, 1'b1, RW_NONE, MW_HALF, RES_ALU, 3'b001};
        tbl[12] = '{'h00309393, 'h00000003, ALU_SLL, 1'b1, RW_WORD, MW_NONE, RES_ALU, 3'b001};
        tbl[13] = '{'hFFF14413, 'hFFFFFFFF, ALU_XOR, 1'b1, RW_WORD, MW_NONE, RES_ALU, 3'b000};
        tbl[14] = '{'hFFE19483, 'hFFFFFFFE, ALU_ADD, 1'b1, RW_HALF, MW_NONE, RES_MEM, 3'b001};
        tbl[15] = '{'h0020A533, 'h00000002, ALU_SLT, 1'b0, RW_WORD, MW_NONE, RES_ALU, 3'b000};
        tbl[BUB] = '0;
    endtask

    // what the registers hold after the edge that just passed
    task automatic stepModel();
        int eNext;
        if (dClr)
            eNext = BUB;
        else if (dEn)
            eNext = dRow;
        else
            eNext = flight[0];
        if (fClr) begin
            dRow = BUB;
            dPc  = '0;
            dPc4 = '0;
        end else if (fEn) begin
            dRow = int'(pcF[5:2]);
            dPc  = pcF;
            dPc4 = pcF + 32'd4;
        end
        flight.push_front(eNext);
        void'(flight.pop_back());
    endtask

    task automatic driveInputs(input int s);
        fClr = 1'b0;
        dClr = (s == FLUSH_AT);
        fEn  = !(s >= STALL_AT && s < STALL_AT + STALLS);
        dEn  = fEn;
        if (nextRow >= NROWS) begin
            fClr = 1'b1; // drain
        end else if (fEn) begin
            pcF = 32'(nextRow * 4);
            nextRow++;
        end
        zeroE = lfsr[0];
        lfsr  = lfsrNext(lfsr);
    endtask

    task automatic checkStages();
        checkVal("instrD", instrD, tbl[dRow].instr);
        checkVal("pcD", pcD, dPc);
        checkVal("pcPlus4D", pcPlus4D, dPc4);
        checkVal("extImmD", extImmD, tbl[dRow].imm);
        checkVal("aluControlE", 32'(aluControlE), 32'(tbl[flight[0]].alu));
        checkVal("aluSrcE", 32'(aluSrcE), 32'(tbl[flight[0]].aluSrc));
        checkVal("regWriteM", 32'(regWriteM), 32'(tbl[flight[1]].regWrite));
        checkVal("memWriteM", 32'(memWriteM), 32'(tbl[flight[1]].memWrite));
        checkVal("regWriteW", 32'(regWriteW), 32'(tbl[flight[2]].regWrite));
        checkVal("resultSrcW", 32'(resultSrcW), 32'(tbl[flight[2]].resultSrc));
    endtask

    initial begin
        arstN   = 1'b0;
        pcF     = '0;
        fEn     = 1'b0;
        fClr    = 1'b0;
        dEn     = 1'b0;
        dClr    = 1'b0;
        zeroE   = 1'b0;
        lfsr    = 32'hfc75_1a7c;
        nextRow = 0;
        errors  = 0;
        checks  = 0;
        dRow    = BUB;
        dPc     = '0;
        dPc4    = '0;
        flight  = '{BUB, BUB, BUB};
        loadTable();
        repeat (RST_CYC) @(posedge clk);
        #2;
        arstN = 1'b1;
        driveInputs(0);
        #1;
        checkVal("regWriteM after reset", 32'(regWriteM), 32'(RW_NONE));
        checkVal("memWriteM after reset", 32'(memWriteM), 32'(MW_NONE));
        checkVal("regWriteW after reset", 32'(regWriteW), 32'(RW_NONE));
        checkVal("pcSrcE after reset", 32'(pcSrcE), 32'(PC_SEQ));
        for (int s = 1; s <= NSTEPS; s++) begin
            @(posedge clk);
            stepModel();
            #2;
            checkStages();
            driveInputs(s);
            #1;
            checkVal("pcSrcE", 32'(pcSrcE), 32'(expPcSrc(tbl[flight[0]], zeroE)));
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/ctrlPkg.sv
verilog/fetchStage.sv
decode/ctrlDecoder.sv
decode/immExtend.sv
verilog/ctrlPipe.sv
verilog/controlTop.sv
sim/tb_controlTop.sv

// ==== verilog/controlTop.sv ====
`default_nettype none

module controlTop
    import ctrlPkg::*;
(
    input  logic             clk,
    input  logic             arstN_i,
    input  logic [XLEN-1:0]  pcF_i,
    input  logic             fEn_i,
    input  logic             fClr_i,
    input  logic             dEn_i,
    input  logic             dClr_i,
    input  logic             zeroE_i,
    output instrWord_u       instrD_o,
    output logic [XLEN-1:0]  pcD_o,
    output logic [XLEN-1:0]  pcPlus4D_o,
    output logic [XLEN-1:0]  extImmD_o,
    output logic [2:0]       aluControlE_o,
    output logic             aluSrcE_o,
    output logic [1:0]       pcSrcE_o,
    output logic [2:0]       regWriteM_o,
    output logic [1:0]       memWriteM_o,
    output logic [2:0]       regWriteW_o,
    output logic [1:0]       resultSrcW_o
);

    logic [2:0] regWriteD;
    logic [1:0] memWriteD;
    logic [1:0] resultSrcD;
    logic [2:0] aluControlD;
    logic       aluSrcD;
    logic [2:0] immSrcD;
    logic       jumpD;
    logic       branchD;

    fetchStage i_fetchStage (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .en_i       (fEn_i),
        .clr_i      (fClr_i),
        .pcF_i      (pcF_i),
        .instrD_o   (instrD_o),
        .pcD_o      (pcD_o),
        .pcPlus4D_o (pcPlus4D_o)
    );

    ctrlDecoder i_ctrlDecoder (
        .instr_i      (instrD_o),
        .regWrite_o   (regWriteD),
        .memWrite_o   (memWriteD),
        .resultSrc_o  (resultSrcD),
        .aluControl_o (aluControlD),
        .aluSrc_o     (aluSrcD),
        .immSrc_o     (immSrcD),
        .jump_o       (jumpD),
        .branch_o     (branchD)
    );

    immExtend i_immExtend (
        .instr_i  (instrD_o),
        .immSrc_i (immSrcD),
        .extImm_o (extImmD_o)
    );

    ctrlPipe i_ctrlPipe (
        .clk           (clk),
        .arstN_i       (arstN_i),
        .en_i          (dEn_i),
        .clr_i         (dClr_i),
        .regWriteD_i   (regWriteD),
        .memWriteD_i   (memWriteD),
        .resultSrcD_i  (resultSrcD),
        .aluControlD_i (aluControlD),
        .aluSrcD_i     (aluSrcD),
        .jumpD_i       (jumpD),
        .branchD_i     (branchD),
        .funct3b0D_i   (instrD_o.ri.funct3[0]), // beq vs bne
        .zeroE_i       (zeroE_i),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .pcSrcE_o      (pcSrcE_o),
        .regWriteM_o   (regWriteM_o),
        .memWriteM_o   (memWriteM_o),
        .regWriteW_o   (regWriteW_o),
        .resultSrcW_o  (resultSrcW_o)
    );

endmodule

`default_nettype wire

// ==== verilog/ctrlPipe.sv ====
`default_nettype none

module ctrlPipe
    import ctrlPkg::*;
(
    input  logic        clk,
    input  logic        arstN_i,
    input  logic        en_i,
    input  logic        clr_i,
    input  logic [2:0]  regWriteD_i,
    input  logic [1:0]  memWriteD_i,
    input  logic [1:0]  resultSrcD_i,
    input  logic [2:0]  aluControlD_i,
    input  logic        aluSrcD_i,
    input  logic        jumpD_i,
    input  logic        branchD_i,
    input  logic        funct3b0D_i,
    input  logic        zeroE_i,
    output logic [2:0]  aluControlE_o,
    output logic        aluSrcE_o,
    output logic [1:0]  pcSrcE_o,
    output logic [2:0]  regWriteM_o,
    output logic [1:0]  memWriteM_o,
    output logic [2:0]  regWriteW_o,
    output logic [1:0]  resultSrcW_o
);

    logic [2:0] regWriteE;
    logic [1:0] memWriteE;
    logic [1:0] resultSrcE;
    logic       jumpE;
    logic       branchE;
    logic       funct3b0E;
    logic [1:0] resultSrcM;
    logic       taken;

    // decode to execute, clear wins over enable
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteE     <= RW_NONE;
            memWriteE     <= MW_NONE;
            resultSrcE    <= RES_ALU;
            aluControlE_o <= ALU_ADD;
            aluSrcE_o     <= 1'b0;
            jumpE         <= 1'b0;
            branchE       <= 1'b0;
            funct3b0E     <= 1'b0;
        end else if (clr_i) begin
            regWriteE     <= RW_NONE;
            memWriteE     <= MW_NONE;
            resultSrcE    <= RES_ALU;
            aluControlE_o <= ALU_ADD;
            aluSrcE_o     <= 1'b0;
            jumpE         <= 1'b0;
            branchE       <= 1'b0;
            funct3b0E     <= 1'b0;
        end else if (en_i) begin
            regWriteE     <= regWriteD_i;
            memWriteE     <= memWriteD_i;
            resultSrcE    <= resultSrcD_i;
            aluControlE_o <= aluControlD_i;
            aluSrcE_o     <= aluSrcD_i;
            jumpE         <= jumpD_i;
            branchE       <= branchD_i;
            funct3b0E     <= funct3b0D_i;
        end
    end

    // execute to memory to writeback, never stalled
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            regWriteM_o  <= RW_NONE;
            memWriteM_o  <= MW_NONE;
            resultSrcM   <= RES_ALU;
            regWriteW_o  <= RW_NONE;
            resultSrcW_o <= RES_ALU;
        end else begin
            regWriteM_o  <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM   <= resultSrcE;
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM;
        end
    end

    assign taken = branchE & (zeroE_i ^ funct3b0E); // beq on zero, bne on nonzero

    always_comb begin
        if (jumpE) pcSrcE_o = PC_JUMP;
        else if (taken) pcSrcE_o = PC_BRANCH;
        else pcSrcE_o = PC_SEQ;
    end

    // decoder never marks one instruction as both
    aJumpXorBranch: assert property (@(posedge clk) disable iff (!arstN_i)
        !(jumpE && branchE));

endmodule

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`default_nettype none

module fetchStage
    import ctrlPkg::*;
(
    input  logic             clk,
    input  logic             arstN_i,
    input  logic             en_i,
    input  logic             clr_i,
    input  logic [XLEN-1:0]  pcF_i,
    output instrWord_u       instrD_o,
    output logic [XLEN-1:0]  pcD_o,
    output logic [XLEN-1:0]  pcPlus4D_o
);

    logic [XLEN-1:0] rom [IMEM_DEPTH];
    logic [XLEN-1:0] instrF;
    logic [XLEN-1:0] pcPlus4F;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign instrF   = rom[pcF_i[IMEM_AW+1:2]]; // word addressed
    assign pcPlus4F = pcF_i + XLEN'(4);

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            instrD_o   <= '0;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (clr_i) begin
            // zero word decodes as illegal, so this is a bubble
            instrD_o   <= '0;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (en_i) begin
            instrD_o   <= instrF;
            pcD_o      <= pcF_i;
            pcPlus4D_o <= pcPlus4F;
        end
    end

endmodule

`default_nettype wire
